// File: vlog.f
verilog/lane_pkg.sv
verilog/operand_fifo.sv
verilog/valu.sv
verilog/vmul.sv
verilog/wb_arbiter.sv
verilog/vector_fus_stage.sv
verif/fus_checker.sv
verif/fus_asserts.sv
verif/tb_vector_fus_stage.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_vector_fus_stage
FILELIST := vlog.f
OBJ_DIR  := obj_dir
PASS_MSG := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_vector_fus_stage.sv
// Testbench for the lane execution stage with random instructions, operands and writeback stalls
`timescale 1ns/1ns

module tb_vector_fus_stage
  import lane_pkg::*;
();

  localparam int NumInsns   = 60;
  localparam int TimeoutCyc = NumInsns * MaxVl * 6;

  logic               clk_i;
  logic               rst_n_i;
  logic               vfu_op_valid_i;
  vfu_op_e            vfu_op_i;
  vid_t               vfu_id_i;
  logic [2:0]         vfu_vd_i;
  vl_t                vfu_vl_i;
  logic               alu_ready_o;
  logic               mul_ready_o;
  logic [NrVInsn-1:0] alu_vinsn_done_o;
  logic [NrVInsn-1:0] mul_vinsn_done_o;
  logic               alu_operand_valid_i;
  elen_t              alu_operand_a_i;
  elen_t              alu_operand_b_i;
  logic               alu_operand_credit_o;
  logic               mul_operand_valid_i;
  elen_t              mul_operand_a_i;
  elen_t              mul_operand_b_i;
  logic               mul_operand_credit_o;
  logic               wb_req_o;
  vid_t               wb_id_o;
  vaddr_t             wb_addr_o;
  elen_t              wb_data_o;
  logic               wb_gnt_i;
  logic               run_end;
  int                 mismatch_cnt;
  int                 error_cnt;

  logic [31:0] rand_state;
  vid_t        free_ids[$];
  // Operand pairs still to send with a in the upper word
  logic [63:0] alu_pairs[$];
  logic [63:0] mul_pairs[$];
  int          alu_credits;
  int          mul_credits;
  int          issued;
  int          finished;
  int          cycle;
  int          tb_errors;
  int          assert_fails;
  logic        timed_out;

  always #10 clk_i = ~clk_i;

  vector_fus_stage i_vector_fus_stage (.*);

  fus_checker i_fus_checker (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .op_valid_i(vfu_op_valid_i), .op_i(vfu_op_i), .id_i(vfu_id_i), .vd_i(vfu_vd_i),
    .vl_i(vfu_vl_i), .alu_ready_i(alu_ready_o), .mul_ready_i(mul_ready_o),
    .alu_done_i(alu_vinsn_done_o), .mul_done_i(mul_vinsn_done_o),
    .alu_push_i(alu_operand_valid_i), .alu_a_i(alu_operand_a_i), .alu_b_i(alu_operand_b_i),
    .alu_credit_i(alu_operand_credit_o),
    .mul_push_i(mul_operand_valid_i), .mul_a_i(mul_operand_a_i), .mul_b_i(mul_operand_b_i),
    .mul_credit_i(mul_operand_credit_o),
    .wb_req_i(wb_req_o), .wb_id_i(wb_id_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
    .wb_gnt_i(wb_gnt_i), .end_i(run_end),
    .mismatch_cnt_o(mismatch_cnt), .error_cnt_o(error_cnt)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rand_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rand_state = x;
    return x;
  endfunction

  function automatic logic targets_mul(vfu_op_e op);
    return (op == OP_MUL) || (op == OP_MULH);
  endfunction

  task automatic queue_operands(input logic is_mul, input vl_t vl);
    logic [63:0] pair;
    for (int e = 0; e <= int'(vl); e++) begin
      pair = {next_rand(), next_rand()};
      if (is_mul) mul_pairs.push_back(pair);
      else alu_pairs.push_back(pair);
    end
  endtask

  initial begin
    logic pending;
    clk_i               = 1'b0;
    rst_n_i             = 1'b0;
    vfu_op_valid_i      = 1'b0;
    vfu_op_i            = OP_ADD;
    vfu_id_i            = '0;
    vfu_vd_i            = '0;
    vfu_vl_i            = '0;
    alu_operand_valid_i = 1'b0;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    mul_operand_valid_i = 1'b0;
    mul_operand_a_i     = '0;
    mul_operand_b_i     = '0;
    wb_gnt_i            = 1'b0;
    run_end             = 1'b0;
    rand_state          = 32'd76;
    alu_credits         = OperandDepth;
    mul_credits         = OperandDepth;
    issued              = 0;
    finished            = 0;
    cycle               = 0;
    tb_errors           = 0;
    assert_fails        = 0;
    timed_out           = 1'b0;
    pending             = 1'b0;
    for (int i = 0; i < NrVInsn; i++) free_ids.push_back(vid_t'(i));
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    while (finished < NumInsns && !timed_out) begin
      @(posedge clk_i);
      cycle++;
      if (cycle > TimeoutCyc) begin
        $display("Timeout after %0d cycles, %0d of %0d instructions done",
                 cycle, finished, NumInsns);
        timed_out = 1'b1;
      end
      if (alu_operand_credit_o) alu_credits++;
      if (mul_operand_credit_o) mul_credits++;
      for (int i = 0; i < NrVInsn; i++) begin
        if (alu_vinsn_done_o[i] || mul_vinsn_done_o[i]) begin
          free_ids.push_back(vid_t'(i));
          finished++;
        end
      end
      // Sequencer holds its instruction until the target unit takes it
      if (pending && (targets_mul(vfu_op_i) ? mul_ready_o : alu_ready_o)) begin
        queue_operands(targets_mul(vfu_op_i), vfu_vl_i);
        issued++;
        pending = 1'b0;
      end
      if (!pending && issued < NumInsns && free_ids.size() > 0) begin
        vfu_op_i <= vfu_op_e'(3'(next_rand() % 7));
        vfu_vl_i <= vl_t'(next_rand() % MaxVl);
        vfu_vd_i <= 3'(next_rand());
        vfu_id_i <= free_ids.pop_front();
        pending = 1'b1;
      end
      vfu_op_valid_i <= pending;
      // Operand sends with random gaps and never beyond the credits held
      if (alu_pairs.size() > 0 && alu_credits > 0 && next_rand() % 4 != 0) begin
        alu_operand_valid_i <= 1'b1;
        {alu_operand_a_i, alu_operand_b_i} <= alu_pairs.pop_front();
        alu_credits--;
      end else begin
        alu_operand_valid_i <= 1'b0;
      end
      if (mul_pairs.size() > 0 && mul_credits > 0 && next_rand() % 4 != 0) begin
        mul_operand_valid_i <= 1'b1;
        {mul_operand_a_i, mul_operand_b_i} <= mul_pairs.pop_front();
        mul_credits--;
      end else begin
        mul_operand_valid_i <= 1'b0;
      end
      wb_gnt_i <= (next_rand() % 3) != 0;
    end

    vfu_op_valid_i      <= 1'b0;
    alu_operand_valid_i <= 1'b0;
    mul_operand_valid_i <= 1'b0;
    run_end             <= 1'b1;
    repeat (2) @(posedge clk_i);
    if (alu_credits != OperandDepth || mul_credits != OperandDepth) begin
      $display("Credits held at the end are %0d and %0d instead of %0d",
               alu_credits, mul_credits, OperandDepth);
      tb_errors++;
    end
    if (timed_out) tb_errors++;
    assert_fails = i_vector_fus_stage.i_fus_asserts.fail_count;
    $display("Error counts: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatch_cnt, error_cnt + tb_errors, assert_fails);
    if (mismatch_cnt == 0 && error_cnt + tb_errors == 0 && assert_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_vector_fus_stage

// File: verif/fus_asserts.sv
// Handshake assertions on operand credits, unit result requests and done outputs
`timescale 1ns/1ns

module fus_asserts import lane_pkg::*; (
  input logic                                      clk_i,
  input logic                                      rst_n_i,
  input logic                                      alu_push_i,
  input logic                                      alu_credit_i,
  input logic                                      mul_push_i,
  input logic                                      mul_credit_i,
  input logic                                      alu_req_i,
  input logic                                      alu_gnt_i,
  input logic [$bits(vid_t)+$bits(vaddr_t)+31:0]   alu_res_i,
  input logic                                      mul_req_i,
  input logic                                      mul_gnt_i,
  input logic [$bits(vid_t)+$bits(vaddr_t)+31:0]   mul_res_i,
  input logic [NrVInsn-1:0]                        alu_done_i,
  input logic [NrVInsn-1:0]                        mul_done_i
);

  // Credits the producer holds
  int alu_credits;
  int mul_credits;

  // Number of failed assertions
  int fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_credits <= OperandDepth;
      mul_credits <= OperandDepth;
    end else begin
      alu_credits <= alu_credits - int'(alu_push_i) + int'(alu_credit_i);
      mul_credits <= mul_credits - int'(mul_push_i) + int'(mul_credit_i);
    end
  end

  alu_push_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alu_push_i |-> alu_credits > 0)
  else begin
    $error("ALU operand pushed without a credit");
    fail_count++;
  end

  mul_push_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_push_i |-> mul_credits > 0)
  else begin
    $error("multiplier operand pushed without a credit");
    fail_count++;
  end

  alu_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alu_req_i && !alu_gnt_i |=> alu_req_i && $stable(alu_res_i))
  else begin
    $error("ALU request changed before its grant");
    fail_count++;
  end

  mul_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_req_i && !mul_gnt_i |=> mul_req_i && $stable(mul_res_i))
  else begin
    $error("multiplier request changed before its grant");
    fail_count++;
  end

  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(alu_done_i) && $onehot0(mul_done_i))
  else begin
    $error("done output with more than one bit set");
    fail_count++;
  end

endmodule : fus_asserts

bind vector_fus_stage fus_asserts i_fus_asserts (
  .clk_i(clk_i),
  .rst_n_i(rst_n_i),
  .alu_push_i(alu_operand_valid_i),
  .alu_credit_i(alu_operand_credit_o),
  .mul_push_i(mul_operand_valid_i),
  .mul_credit_i(mul_operand_credit_o),
  .alu_req_i(alu_req),
  .alu_gnt_i(alu_gnt),
  .alu_res_i({alu_id, alu_addr, alu_data}),
  .mul_req_i(mul_req),
  .mul_gnt_i(mul_gnt),
  .mul_res_i({mul_id, mul_addr, mul_data}),
  .alu_done_i(alu_vinsn_done_o),
  .mul_done_i(mul_vinsn_done_o)
);

// File: verif/fus_checker.sv
// Scoreboard that models the register file and the in-flight instructions and checks each write
`timescale 1ns/1ns

module fus_checker import lane_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               op_valid_i,
  input  vfu_op_e            op_i,
  input  vid_t               id_i,
  input  logic [2:0]         vd_i,
  input  vl_t                vl_i,
  input  logic               alu_ready_i,
  input  logic               mul_ready_i,
  input  logic [NrVInsn-1:0] alu_done_i,
  input  logic [NrVInsn-1:0] mul_done_i,
  input  logic               alu_push_i,
  input  elen_t              alu_a_i,
  input  elen_t              alu_b_i,
  input  logic               alu_credit_i,
  input  logic               mul_push_i,
  input  elen_t              mul_a_i,
  input  elen_t              mul_b_i,
  input  logic               mul_credit_i,
  input  logic               wb_req_i,
  input  vid_t               wb_id_i,
  input  vaddr_t             wb_addr_i,
  input  elen_t              wb_data_i,
  input  logic               wb_gnt_i,
  input  logic               end_i,
  output int                 mismatch_cnt_o,
  output int                 error_cnt_o
);

  elen_t       rf_exp [64];
  elen_t       rf_act [64];
  logic [63:0] alu_q[$];
  logic [63:0] mul_q[$];
  // Per-id instruction state
  logic        act [NrVInsn];
  logic        on_mul [NrVInsn];
  vfu_op_e     ins_op [NrVInsn];
  logic [2:0]  ins_vd [NrVInsn];
  int          ins_len [NrVInsn];
  int          written [NrVInsn];
  int          last_wr [NrVInsn];
  logic        alu_busy;
  logic        mul_busy;
  logic        reset_seen = 1'b0;
  logic        ended = 1'b0;
  int          cycle;
  int          alu_pushes;
  int          mul_pushes;
  int          alu_credits;
  int          mul_credits;
  int          mismatches = 0;
  int          errors = 0;

  assign mismatch_cnt_o = mismatches;
  assign error_cnt_o    = errors;

  function automatic elen_t compute_expected(vfu_op_e op, elen_t a, elen_t b);
    logic [63:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MUL:  return prod[31:0];
      default: return prod[63:32];
    endcase
  endfunction

  task automatic report_mismatch(input string test, input elen_t exp, input elen_t act_val);
    $display("MISMATCH %s expected %08h actual %08h", test, exp, act_val);
    mismatches++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s", msg);
    errors++;
  endtask

  task automatic check_done(input logic [NrVInsn-1:0] done, input logic mul_unit);
    if (!$onehot0(done)) report_error($sformatf("done output %b has several bits set", done));
    for (int i = 0; i < NrVInsn; i++) begin
      if (done[i]) begin
        if (!act[i] || on_mul[i] != mul_unit) begin
          report_error($sformatf("done for id %0d which is not in flight on this unit", i));
        end else begin
          if (written[i] != ins_len[i]) begin
            report_error($sformatf("done for id %0d after %0d of %0d writes",
                                   i, written[i], ins_len[i]));
          end else if (last_wr[i] != cycle - 1) begin
            report_error($sformatf("done for id %0d not in the cycle after its last write", i));
          end
          act[i] = 1'b0;
          if (mul_unit) mul_busy = 1'b0;
          else alu_busy = 1'b0;
        end
      end
    end
  endtask

  task automatic check_write();
    logic [63:0] pair;
    vaddr_t      exp_addr;
    elen_t       exp_data;
    if (!act[wb_id_i]) begin
      report_error($sformatf("write for id %0d with no instruction in flight", wb_id_i));
    end else if (written[wb_id_i] >= ins_len[wb_id_i]) begin
      report_error($sformatf("extra write for id %0d", wb_id_i));
    end else if (on_mul[wb_id_i] ? mul_q.size() == 0 : alu_q.size() == 0) begin
      report_error($sformatf("write for id %0d without a sent operand pair", wb_id_i));
    end else begin
      pair     = on_mul[wb_id_i] ? mul_q.pop_front() : alu_q.pop_front();
      exp_addr = {ins_vd[wb_id_i], VlWidth'(written[wb_id_i])};
      exp_data = compute_expected(ins_op[wb_id_i], pair[63:32], pair[31:0]);
      if (wb_addr_i !== exp_addr) report_mismatch("wb_addr", 32'(exp_addr), 32'(wb_addr_i));
      if (wb_data_i !== exp_data) begin
        report_mismatch(on_mul[wb_id_i] ? "mul_data" : "alu_data", exp_data, wb_data_i);
      end
      rf_exp[exp_addr] = exp_data;
      written[wb_id_i]++;
      last_wr[wb_id_i] = cycle;
    end
    rf_act[wb_addr_i] = wb_data_i;
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      if (reset_seen && (wb_req_i || alu_credit_i || mul_credit_i ||
          (alu_done_i | mul_done_i) != '0 || !alu_ready_i || !mul_ready_i)) begin
        report_error("outputs differ from their reset values");
      end
      reset_seen  = 1'b1;
      alu_busy    = 1'b0;
      mul_busy    = 1'b0;
      cycle       = 0;
      alu_pushes  = 0;
      mul_pushes  = 0;
      alu_credits = 0;
      mul_credits = 0;
      alu_q.delete();
      mul_q.delete();
      for (int i = 0; i < NrVInsn; i++) act[i] = 1'b0;
      for (int a = 0; a < 64; a++) begin
        rf_exp[a] = '0;
        rf_act[a] = '0;
      end
    end else if (!ended) begin
      cycle++;
      if (alu_ready_i && alu_busy) report_error("ALU ready while its instruction is unfinished");
      if (mul_ready_i && mul_busy) begin
        report_error("multiplier ready while its instruction is unfinished");
      end
      // A credit may only follow an operand pair that was sent earlier
      if (alu_credit_i) begin
        if (alu_credits >= alu_pushes) report_error("ALU credit returned with nothing sent");
        alu_credits++;
      end
      if (mul_credit_i) begin
        if (mul_credits >= mul_pushes) report_error("multiplier credit returned with nothing sent");
        mul_credits++;
      end
      check_done(alu_done_i, 1'b0);
      check_done(mul_done_i, 1'b1);
      if (wb_req_i && wb_gnt_i) check_write();
      if (op_valid_i && ((op_i == OP_MUL || op_i == OP_MULH) ? mul_ready_i : alu_ready_i)) begin
        if (act[id_i]) report_error($sformatf("issue of id %0d while still in flight", id_i));
        act[id_i]     = 1'b1;
        on_mul[id_i]  = (op_i == OP_MUL || op_i == OP_MULH);
        ins_op[id_i]  = op_i;
        ins_vd[id_i]  = vd_i;
        ins_len[id_i] = int'(vl_i) + 1;
        written[id_i] = 0;
        if (on_mul[id_i]) mul_busy = 1'b1;
        else alu_busy = 1'b1;
      end
      if (alu_push_i) begin
        alu_q.push_back({alu_a_i, alu_b_i});
        alu_pushes++;
      end
      if (mul_push_i) begin
        mul_q.push_back({mul_a_i, mul_b_i});
        mul_pushes++;
      end
      if (end_i) begin
        ended = 1'b1;
        for (int i = 0; i < NrVInsn; i++) begin
          if (act[i]) report_error($sformatf("instruction id %0d never finished", i));
        end
        if (alu_credits != alu_pushes || mul_credits != mul_pushes) begin
          report_error($sformatf("credits returned %0d/%0d but pairs sent %0d/%0d",
                                 alu_credits, mul_credits, alu_pushes, mul_pushes));
        end
        if (alu_q.size() != 0 || mul_q.size() != 0) report_error("operand pairs left unused");
        for (int a = 0; a < 64; a++) begin
          if (rf_act[a] !== rf_exp[a]) report_mismatch("rf_final", rf_exp[a], rf_act[a]);
        end
      end
    end
  end

endmodule : fus_checker

// File: verilog/vector_fus_stage.sv
// Lane execution stage with ALU and multiplier sharing issue and writeback ports
`timescale 1ns/1ns

module vector_fus_stage import lane_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Sequencer issue
  input  logic               vfu_op_valid_i,
  input  vfu_op_e            vfu_op_i,
  input  vid_t               vfu_id_i,
  input  logic [2:0]         vfu_vd_i,
  input  vl_t                vfu_vl_i,
  output logic               alu_ready_o,
  output logic               mul_ready_o,
  output logic [NrVInsn-1:0] alu_vinsn_done_o,
  output logic [NrVInsn-1:0] mul_vinsn_done_o,
  // Operand channels
  input  logic               alu_operand_valid_i,
  input  elen_t              alu_operand_a_i,
  input  elen_t              alu_operand_b_i,
  output logic               alu_operand_credit_o,
  input  logic               mul_operand_valid_i,
  input  elen_t              mul_operand_a_i,
  input  elen_t              mul_operand_b_i,
  output logic               mul_operand_credit_o,
  // Register file writeback
  output logic               wb_req_o,
  output vid_t               wb_id_o,
  output vaddr_t             wb_addr_o,
  output elen_t              wb_data_o,
  input  logic               wb_gnt_i
);

  logic   is_mul_op, alu_issue, mul_issue;
  logic   alu_empty, alu_pop, mul_empty, mul_pop;
  elen_t  alu_a, alu_b, mul_a, mul_b;
  logic   alu_req, alu_gnt, mul_req, mul_gnt;
  vid_t   alu_id, mul_id;
  vaddr_t alu_addr, mul_addr;
  elen_t  alu_data, mul_data;

  // Opcode class picks the target unit
  assign is_mul_op = (vfu_op_i == OP_MUL) | (vfu_op_i == OP_MULH);
  assign alu_issue = vfu_op_valid_i & ~is_mul_op & alu_ready_o;
  assign mul_issue = vfu_op_valid_i & is_mul_op & mul_ready_o;

  operand_fifo #(.Depth(OperandDepth)) i_alu_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_i(alu_operand_valid_i), .push_a_i(alu_operand_a_i), .push_b_i(alu_operand_b_i),
    .pop_i(alu_pop), .empty_o(alu_empty), .a_o(alu_a), .b_o(alu_b),
    .credit_o(alu_operand_credit_o)
  );

  operand_fifo #(.Depth(OperandDepth)) i_mul_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_i(mul_operand_valid_i), .push_a_i(mul_operand_a_i), .push_b_i(mul_operand_b_i),
    .pop_i(mul_pop), .empty_o(mul_empty), .a_o(mul_a), .b_o(mul_b),
    .credit_o(mul_operand_credit_o)
  );

  valu i_valu (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .issue_i(alu_issue), .op_i(vfu_op_i), .id_i(vfu_id_i), .vd_i(vfu_vd_i), .vl_i(vfu_vl_i),
    .ready_o(alu_ready_o),
    .opnd_empty_i(alu_empty), .opnd_a_i(alu_a), .opnd_b_i(alu_b), .opnd_pop_o(alu_pop),
    .res_req_o(alu_req), .res_id_o(alu_id), .res_addr_o(alu_addr), .res_data_o(alu_data),
    .res_gnt_i(alu_gnt), .done_o(alu_vinsn_done_o)
  );

  vmul i_vmul (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .issue_i(mul_issue), .op_i(vfu_op_i), .id_i(vfu_id_i), .vd_i(vfu_vd_i), .vl_i(vfu_vl_i),
    .ready_o(mul_ready_o),
    .opnd_empty_i(mul_empty), .opnd_a_i(mul_a), .opnd_b_i(mul_b), .opnd_pop_o(mul_pop),
    .res_req_o(mul_req), .res_id_o(mul_id), .res_addr_o(mul_addr), .res_data_o(mul_data),
    .res_gnt_i(mul_gnt), .done_o(mul_vinsn_done_o)
  );

  wb_arbiter i_wb_arbiter (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .alu_req_i(alu_req), .alu_id_i(alu_id), .alu_addr_i(alu_addr), .alu_data_i(alu_data),
    .alu_gnt_o(alu_gnt),
    .mul_req_i(mul_req), .mul_id_i(mul_id), .mul_addr_i(mul_addr), .mul_data_i(mul_data),
    .mul_gnt_o(mul_gnt),
    .wb_req_o(wb_req_o), .wb_id_o(wb_id_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o),
    .wb_gnt_i(wb_gnt_i)
  );

endmodule : vector_fus_stage

// File: verilog/wb_arbiter.sv
// Round-robin arbiter sharing the one writeback port between the ALU and the multiplier
`timescale 1ns/1ns

module wb_arbiter import lane_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  // ALU requester
  input  logic   alu_req_i,
  input  vid_t   alu_id_i,
  input  vaddr_t alu_addr_i,
  input  elen_t  alu_data_i,
  output logic   alu_gnt_o,
  // Multiplier requester
  input  logic   mul_req_i,
  input  vid_t   mul_id_i,
  input  vaddr_t mul_addr_i,
  input  elen_t  mul_data_i,
  output logic   mul_gnt_o,
  // Register file write port
  output logic   wb_req_o,
  output vid_t   wb_id_o,
  output vaddr_t wb_addr_o,
  output elen_t  wb_data_o,
  input  logic   wb_gnt_i
);

  // High when the multiplier took the last committed write
  logic last_mul_q;
  logic sel_mul;
  logic commit;

  // On a tie the unit not granted last wins
  assign sel_mul = mul_req_i & (~alu_req_i | ~last_mul_q);

  assign wb_req_o  = alu_req_i | mul_req_i;
  assign wb_id_o   = sel_mul ? mul_id_i : alu_id_i;
  assign wb_addr_o = sel_mul ? mul_addr_i : alu_addr_i;
  assign wb_data_o = sel_mul ? mul_data_i : alu_data_i;

  assign commit    = wb_req_o & wb_gnt_i;
  assign alu_gnt_o = commit & ~sel_mul;
  assign mul_gnt_o = commit & sel_mul;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_mul_q <= 1'b0;
    end else if (commit) begin
      last_mul_q <= sel_mul;
    end
  end

endmodule : wb_arbiter

// File: verilog/vmul.sv
// Pipelined vector multiplier returning the low or high word of the unsigned product
`timescale 1ns/1ns

module vmul import lane_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Issue from the sequencer, OP_MUL or OP_MULH only
  input  logic               issue_i,
  input  vfu_op_e            op_i,
  input  vid_t               id_i,
  input  logic [2:0]         vd_i,
  input  vl_t                vl_i,
  output logic               ready_o,
  // Operand queue
  input  logic               opnd_empty_i,
  input  elen_t              opnd_a_i,
  input  elen_t              opnd_b_i,
  output logic               opnd_pop_o,
  // Result towards the writeback arbiter
  output logic               res_req_o,
  output vid_t               res_id_o,
  output vaddr_t             res_addr_o,
  output elen_t              res_data_o,
  input  logic               res_gnt_i,
  output logic [NrVInsn-1:0] done_o
);

  typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_e;

  mul_state_e           state_q;
  vfu_op_e              op_q;
  vid_t                 id_q;
  logic [2:0]           vd_q;
  vl_t                  vl_q;
  vl_t                  elem_q;
  logic                 all_popped_q;
  logic [VlWidth:0]     pend_q;
  logic [MulStages-1:0] vld_q;
  vaddr_t               addr_q [MulStages];
  vid_t                 sid_q [MulStages];
  elen_t                opa_q;
  elen_t                opb_q;
  logic [63:0]          prod_q;
  elen_t                word_q;
  logic                 adv;
  logic                 last_commit;

  // Whole pipeline freezes behind an ungranted result
  assign adv         = ~vld_q[MulStages-1] | res_gnt_i;
  assign opnd_pop_o  = (state_q == MUL_RUN) & ~all_popped_q & ~opnd_empty_i & adv;
  assign last_commit = vld_q[MulStages-1] & res_gnt_i & (pend_q == (VlWidth + 1)'(1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= MUL_IDLE;
      elem_q       <= '0;
      all_popped_q <= 1'b0;
      pend_q       <= '0;
      vld_q        <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: begin
          if (issue_i) begin
            state_q      <= MUL_RUN;
            elem_q       <= '0;
            all_popped_q <= 1'b0;
            pend_q       <= {1'b0, vl_i} + 1'b1;
          end
        end
        MUL_RUN: begin
          if (last_commit) state_q <= MUL_DONE;
        end
        default: state_q <= MUL_IDLE;
      endcase
      if (opnd_pop_o) begin
        elem_q <= elem_q + 1'b1;
        if (elem_q == vl_q) all_popped_q <= 1'b1;
      end
      // Writes still owed to the register file
      if (vld_q[MulStages-1] && res_gnt_i) pend_q <= pend_q - 1'b1;
      if (adv) vld_q <= {vld_q[MulStages-2:0], opnd_pop_o};
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      op_q <= op_i;
      id_q <= id_i;
      vd_q <= vd_i;
      vl_q <= vl_i;
    end
    if (adv) begin
      addr_q[0] <= {vd_q, elem_q};
      sid_q[0]  <= id_q;
      for (int i = 1; i < MulStages; i++) begin
        addr_q[i] <= addr_q[i-1];
        sid_q[i]  <= sid_q[i-1];
      end
      // Operands, then the full product, then the selected word
      opa_q  <= opnd_a_i;
      opb_q  <= opnd_b_i;
      prod_q <= 64'(opa_q) * 64'(opb_q);
      word_q <= (op_q == OP_MULH) ? prod_q[63:32] : prod_q[31:0];
    end
  end

  always_comb begin
    done_o = '0;
    if (state_q == MUL_DONE) done_o[id_q] = 1'b1;
  end

  assign ready_o    = (state_q == MUL_IDLE);
  assign res_req_o  = vld_q[MulStages-1];
  assign res_id_o   = sid_q[MulStages-1];
  assign res_addr_o = addr_q[MulStages-1];
  assign res_data_o = word_q;

endmodule : vmul

// File: verilog/valu.sv
// Vector ALU running one instruction at a time, one element per popped operand pair
`timescale 1ns/1ns

module valu import lane_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Issue from the sequencer
  input  logic               issue_i,
  input  vfu_op_e            op_i,
  input  vid_t               id_i,
  input  logic [2:0]         vd_i,
  input  vl_t                vl_i,
  output logic               ready_o,
  // Operand queue
  input  logic               opnd_empty_i,
  input  elen_t              opnd_a_i,
  input  elen_t              opnd_b_i,
  output logic               opnd_pop_o,
  // Result towards the writeback arbiter
  output logic               res_req_o,
  output vid_t               res_id_o,
  output vaddr_t             res_addr_o,
  output elen_t              res_data_o,
  input  logic               res_gnt_i,
  output logic [NrVInsn-1:0] done_o
);

  typedef enum logic [1:0] {ALU_IDLE, ALU_RUN, ALU_DRAIN} alu_state_e;

  alu_state_e state_q;
  vfu_op_e    op_q;
  vid_t       id_q;
  logic [2:0] vd_q;
  vl_t        vl_q;
  vl_t        elem_q;
  logic       all_popped_q;
  logic       res_valid_q;
  logic       res_last_q;
  elen_t      res_data_q;
  vaddr_t     res_addr_q;
  elen_t      result;
  logic       res_free;
  logic       last_commit;

  always_comb begin
    case (op_q)
      OP_SUB:  result = opnd_a_i - opnd_b_i;
      OP_AND:  result = opnd_a_i & opnd_b_i;
      OP_OR:   result = opnd_a_i | opnd_b_i;
      OP_XOR:  result = opnd_a_i ^ opnd_b_i;
      default: result = opnd_a_i + opnd_b_i;
    endcase
  end

  // Result register frees up in the same cycle it is granted
  assign res_free    = ~res_valid_q | res_gnt_i;
  assign opnd_pop_o  = (state_q == ALU_RUN) & ~all_popped_q & ~opnd_empty_i & res_free;
  assign last_commit = res_valid_q & res_gnt_i & res_last_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ALU_IDLE;
      elem_q       <= '0;
      all_popped_q <= 1'b0;
      res_valid_q  <= 1'b0;
    end else begin
      case (state_q)
        ALU_IDLE: begin
          if (issue_i) begin
            state_q      <= ALU_RUN;
            elem_q       <= '0;
            all_popped_q <= 1'b0;
          end
        end
        ALU_RUN: begin
          if (last_commit) state_q <= ALU_DRAIN;
        end
        // One cycle for the done pulse
        default: state_q <= ALU_IDLE;
      endcase
      if (opnd_pop_o) begin
        elem_q <= elem_q + 1'b1;
        if (elem_q == vl_q) all_popped_q <= 1'b1;
      end
      if (opnd_pop_o) begin
        res_valid_q <= 1'b1;
      end else if (res_gnt_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      op_q <= op_i;
      id_q <= id_i;
      vd_q <= vd_i;
      vl_q <= vl_i;
    end
    if (opnd_pop_o) begin
      res_data_q <= result;
      res_addr_q <= {vd_q, elem_q};
      res_last_q <= (elem_q == vl_q);
    end
  end

  always_comb begin
    done_o = '0;
    if (state_q == ALU_DRAIN) done_o[id_q] = 1'b1;
  end

  assign ready_o    = (state_q == ALU_IDLE);
  assign res_req_o  = res_valid_q;
  assign res_id_o   = id_q;
  assign res_addr_o = res_addr_q;
  assign res_data_o = res_data_q;

endmodule : valu

// File: verilog/operand_fifo.sv
// Operand-pair FIFO that hands back one credit for each entry it releases
`timescale 1ns/1ns

module operand_fifo import lane_pkg::*; #(
  parameter int unsigned Depth = OperandDepth
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  elen_t push_a_i,
  input  elen_t push_b_i,
  input  logic  pop_i,
  output logic  empty_o,
  output elen_t a_o,
  output elen_t b_o,
  output logic  credit_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  elen_t mem_a [Depth];
  elen_t mem_b [Depth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_pop;

  assign empty_o = (count_q == '0);
  assign do_pop  = pop_i & ~empty_o;
  assign a_o     = mem_a[rd_ptr_q];
  assign b_o     = mem_b[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      // Pointers wrap at Depth, which need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CntWidth'(push_i) - CntWidth'(do_pop);
      credit_o <= do_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_a[wr_ptr_q] <= push_a_i;
      mem_b[wr_ptr_q] <= push_b_i;
    end
  end

endmodule : operand_fifo

// File: verilog/lane_pkg.sv
// Lane package with element types, opcodes and the sizes shared by the execution stage

package lane_pkg;

  // Instruction ids in flight, one done bit per id
  localparam int unsigned NrVInsn = 4;

  // Longest vector handled by one instruction
  localparam int unsigned MaxVl = 8;
  localparam int unsigned VlWidth = $clog2(MaxVl);

  // Operand queue depth, which is also the producer's starting credit count
  localparam int unsigned OperandDepth = 4;

  // Multiplier latency from operand pop to result request
  localparam int unsigned MulStages = 3;

  // One vector element
  typedef logic [31:0] elen_t;

  // Register number in the upper bits, element index in the lower bits
  typedef logic [3+VlWidth-1:0] vaddr_t;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Element count minus one
  typedef logic [VlWidth-1:0] vl_t;

  // ALU ops first, multiplier ops last
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MUL  = 3'd5,
    OP_MULH = 3'd6
  } vfu_op_e;

endpackage : lane_pkg
